// ==== Bender.yml ====
package:
  name: game_sound_engine

export_include_dirs:
  - .

sources:
  - files:
      - sound_pkg.sv
      - tone_pkg.sv
      - beat_timer.sv
      - game_sound.sv
      - song_sequencer.sv
      - square_voice.sv
      - sound_top.sv
  - target: test
    files:
      - tb_sound_top.sv

// ==== beat_timer.sv ====
// free-running tempo counter, not aligned to song changes; needs TICKS_PER_BEAT of at least 2.
`default_nettype none

module beat_timer #(
    parameter int TICKS_PER_BEAT = 12_500_000
) (
    input  wire  clk,
    input  wire  reset,
    output logic beat
);

    localparam int CNT_W = (TICKS_PER_BEAT > 1) ? $clog2(TICKS_PER_BEAT) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICKS_PER_BEAT - 1);

    logic [CNT_W-1:0] count;
    logic             terminal;

    assign terminal = (count == CNT_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            beat  <= 1'b0;
        end else begin
            count <= terminal ? '0 : count + 1'b1;
            beat  <= terminal; // one pulse per period.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    beat_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        beat |=> !beat
    ) else $error("beat strobe held for more than one cycle");

endmodule

`default_nettype wire

// ==== game_sound.sv ====
// song follows state and mute one cycle late; mute wins over every state.
`default_nettype none

module game_sound (
    input  wire                   clk,
    input  wire                   reset,
    input  wire sound_pkg::game_state_t state,
    input  wire                   mute,
    output sound_pkg::song_id_t   song
);

    import sound_pkg::*;

    song_id_t song_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state to song map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (mute) begin
            song_next = SONG_SILENT;
        end else begin
            case (state)
                TITLE: begin
                    song_next = SONG_TITLE;
                end
                STAFF: begin
                    song_next = SONG_STAFF;
                end
                STAGE1, STAGE2, STAGE3: begin
                    song_next = SONG_STAGE; // all stages share a tune.
                end
                SUCCESS1, SUCCESS2, SUCCESS3: begin
                    song_next = SONG_SUCCESS;
                end
                FAIL: begin
                    song_next = SONG_FAIL;
                end
                HELP: begin
                    song_next = SONG_HELP;
                end
                default: begin
                    song_next = SONG_SILENT; // codes 10 to 15.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            song <= SONG_SILENT;
        end else begin
            song <= song_next;
        end
    end

    mute_gives_silence: assert property (
        @(posedge clk) disable iff (reset)
        mute |=> (song == SONG_SILENT)
    ) else $error("song not silent after mute");

endmodule

`default_nettype wire

// ==== song_sequencer.sv ====
// a new song restarts at beat 0 and takes priority over a beat strobe in the same cycle.
`default_nettype none

module song_sequencer (
    input  wire                      clk,
    input  wire                      reset,
    input  wire sound_pkg::song_id_t song,
    input  wire                      beat,
    output tone_pkg::stereo_note_t   note
);

    import sound_pkg::*;
    import tone_pkg::*;

`include "song_table.svh"

    song_id_t             last_song;
    logic [BEAT_BITS-1:0] index;
    logic [BEAT_BITS-1:0] next_index;
    logic [BEAT_BITS:0]   index_inc;
    logic [BEAT_BITS:0]   song_len;
    logic                 song_changed;

    assign song_changed = (song != last_song);
    assign song_len     = song_length(song);
    assign index_inc    = {1'b0, index} + 1'b1;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // beat index
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (song_changed) begin
            next_index = '0;
        end else if (beat) begin
            if (index_inc >= song_len) begin
                next_index = '0; // wrap to the top of the song.
            end else begin
                next_index = index_inc[BEAT_BITS-1:0];
            end
        end else begin
            next_index = index;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last_song <= SONG_SILENT;
            index     <= '0;
            note      <= NOTE_SILENT;
        end else begin
            last_song <= song;
            index     <= next_index;
            note      <= song_note(song, next_index); // lookup for the coming beat.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    index_in_song: assert property (
        @(posedge clk) disable iff (reset)
        ({1'b0, index} < song_length(last_song))
    ) else $error("beat index %0d past end of song %s", index, last_song.name());

endmodule

`default_nettype wire

// ==== song_table.svh ====
// include after importing sound_pkg and tone_pkg; beats past a song's length read as silence.

function automatic logic [BEAT_BITS:0] song_length(input song_id_t song);
    case (song)
        SONG_TITLE:   return 7'd8;
        SONG_STAFF:   return 7'd4;
        SONG_STAGE:   return 7'd8;
        SONG_SUCCESS: return 7'd4;
        SONG_FAIL:    return 7'd4;
        SONG_HELP:    return 7'd4;
        default:      return 7'd1; // silent song is one rest.
    endcase
endfunction

function automatic stereo_note_t song_note(input song_id_t song,
                                           input logic [BEAT_BITS-1:0] beat);
    stereo_note_t note;
    note = NOTE_SILENT;
    case (song)
        SONG_TITLE: begin
            case (beat)
                6'd0:    note = '{HP_C5, HP_C4};
                6'd1:    note = '{HP_E5, HP_E4};
                6'd2:    note = '{HP_D5, HP_G4};
                6'd3:    note = '{HP_C5, HP_E4};
                6'd4:    note = '{HP_A4, HP_F4};
                6'd5:    note = '{HP_B4, HP_G4};
                6'd6:    note = '{HP_C5, HP_E4};
                6'd7:    note = '{'0, HP_C4};
                default: note = NOTE_SILENT;
            endcase
        end
        SONG_STAFF: begin
            case (beat)
                6'd0:    note = '{HP_G4, HP_B3};
                6'd1:    note = '{HP_A4, HP_C4};
                6'd2:    note = '{HP_B4, HP_D4};
                6'd3:    note = '{HP_C5, HP_E4};
                default: note = NOTE_SILENT;
            endcase
        end
        SONG_STAGE: begin
            case (beat)
                6'd0:    note = '{HP_E4, HP_A3};
                6'd1:    note = '{HP_E4, HP_A3};
                6'd2:    note = '{HP_G4, HP_C4};
                6'd3:    note = '{HP_A4, HP_E4};
                6'd4:    note = '{HP_E4, HP_A3};
                6'd5:    note = '{HP_D4, HP_G3};
                6'd6:    note = '{HP_E4, HP_A3};
                default: note = NOTE_SILENT; // beat 7 rests.
            endcase
        end
        SONG_SUCCESS: begin
            case (beat)
                6'd0:    note = '{HP_C5, HP_E4};
                6'd1:    note = '{HP_E5, HP_G4};
                6'd2:    note = '{HP_D5, HP_B4};
                6'd3:    note = '{HP_C5, HP_C4};
                default: note = NOTE_SILENT;
            endcase
        end
        SONG_FAIL: begin
            case (beat)
                6'd0:    note = '{HP_E4, HP_C4};
                6'd1:    note = '{HP_D4, HP_B3};
                6'd2:    note = '{HP_C4, HP_A3};
                6'd3:    note = '{'0, HP_G3};
                default: note = NOTE_SILENT;
            endcase
        end
        SONG_HELP: begin
            case (beat)
                6'd0:    note = '{HP_A4, HP_F4};
                6'd1:    note = '{'0, HP_F4};
                6'd2:    note = '{HP_A4, HP_C4};
                6'd3:    note = '{'0, HP_C4};
                default: note = NOTE_SILENT;
            endcase
        end
        default: note = NOTE_SILENT;
    endcase
    return note;
endfunction

// ==== sound_pkg.sv ====
// game-state codes must match the game logic; unlisted 4-bit codes are treated as silence.
`default_nettype none

package sound_pkg;

    // states presented by the game logic.
    typedef enum logic [3:0] {
        TITLE    = 4'd0,
        STAFF    = 4'd1,
        STAGE1   = 4'd2,
        SUCCESS1 = 4'd3,
        STAGE2   = 4'd4,
        SUCCESS2 = 4'd5,
        STAGE3   = 4'd6,
        SUCCESS3 = 4'd7,
        FAIL     = 4'd8,
        HELP     = 4'd9
    } game_state_t;

    // one entry per note table.
    typedef enum logic [2:0] {
        SONG_SILENT  = 3'd0,
        SONG_TITLE   = 3'd1,
        SONG_STAFF   = 3'd2,
        SONG_STAGE   = 3'd3,
        SONG_SUCCESS = 3'd4,
        SONG_FAIL    = 3'd5,
        SONG_HELP    = 3'd6
    } song_id_t;

    localparam int BEAT_BITS = 6; // songs up to 64 beats.

endpackage

`default_nettype wire

// ==== sound_top.sv ====
// outputs are raw square waves; volume, mixing and the output driver live outside this block.
`default_nettype none

module sound_top #(
    parameter int TICKS_PER_BEAT = 12_500_000,
    parameter int PRESCALE       = 256
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire sound_pkg::game_state_t state,
    input  wire                         mute,
    output logic                        audio_l,
    output logic                        audio_r
);

    import sound_pkg::*;
    import tone_pkg::*;

    logic         beat;
    song_id_t     song;
    stereo_note_t note;

    beat_timer #(
        .TICKS_PER_BEAT(TICKS_PER_BEAT)
    ) u_beat_timer (
        .clk  (clk),
        .reset(reset),
        .beat (beat)
    );

    game_sound u_game_sound (
        .clk  (clk),
        .reset(reset),
        .state(state),
        .mute (mute),
        .song (song)
    );

    song_sequencer u_song_sequencer (
        .clk  (clk),
        .reset(reset),
        .song (song),
        .beat (beat),
        .note (note)
    );

    // one voice per channel.
    square_voice #(.PRESCALE(PRESCALE)) voice_l (
        .clk        (clk),
        .reset      (reset),
        .half_period(note.left),
        .wave       (audio_l)
    );

    square_voice #(.PRESCALE(PRESCALE)) voice_r (
        .clk        (clk),
        .reset      (reset),
        .half_period(note.right),
        .wave       (audio_r)
    );

endmodule

`default_nettype wire

// ==== square_voice.sv ====
// any change of half_period restarts the wave high; run length is half_period times PRESCALE.
`default_nettype none

module square_voice #(
    parameter int PRESCALE = 256
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire tone_pkg::half_period_t half_period,
    output logic                        wave
);

    import tone_pkg::*;

    localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(PRESCALE - 1);

    half_period_t     last_hp;
    half_period_t     hp_cnt;
    logic [PRE_W-1:0] pre_cnt;
    logic             changed;
    logic             tick;

    assign changed = (half_period != last_hp);
    assign tick    = (pre_cnt == PRE_LAST);

    always_ff @(posedge clk) begin
        if (reset) begin
            last_hp <= '0;
            pre_cnt <= '0;
            hp_cnt  <= '0;
            wave    <= 1'b0;
        end else if (changed) begin
            last_hp <= half_period;
            pre_cnt <= '0;
            hp_cnt  <= '0;
            wave    <= (half_period != '0); // new note starts high.
        end else if (last_hp == '0) begin
            wave <= 1'b0; // rest.
        end else begin
            pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
            if (tick) begin
                if (hp_cnt == last_hp - 1'b1) begin
                    hp_cnt <= '0;
                    wave   <= ~wave;
                end else begin
                    hp_cnt <= hp_cnt + 1'b1;
                end
            end
        end
    end

    silent_is_low: assert property (
        @(posedge clk) disable iff (reset)
        (half_period == '0) |=> !wave
    ) else $error("wave high during a rest");

endmodule

`default_nettype wire

// ==== tb_sound_top.sv ====
// runs with a short beat and no prescale; about a million cycles, stops at the first failure.
`default_nettype none

module tb_sound_top;

    timeunit 1ns;
    timeprecision 100ps;

    import sound_pkg::*;
    import tone_pkg::*;

`include "song_table.svh"

    localparam int TICKS_PER_BEAT = 4096;
    localparam int PRESCALE       = 1;
    localparam int VISITS         = 20;
    localparam int CYCLE_LIMIT    = VISITS * 70 * TICKS_PER_BEAT + 10_000;

    logic         clk;
    logic         reset;
    game_state_t  state;
    logic         mute;
    logic         audio_l;
    logic         audio_r;

    logic [31:0]  rng_state = 32'd3;
    string        test_name = "reset";
    logic         state_applied = 1'b0;
    int           cycles_run = 0;

    // reference model registers.
    int                   cycle_cnt;
    logic                 exp_beat;
    song_id_t             exp_song;
    song_id_t             seen_song;
    logic [BEAT_BITS-1:0] exp_idx;
    stereo_note_t         exp_note;

    // run monitor, index 0 is left.
    logic [1:0]   wave_now;
    half_period_t hp_now [2];
    logic         wave_prev [2];
    half_period_t hp_last [2];
    logic         restart_pend [2];
    int           run_len [2];

    sound_top #(
        .TICKS_PER_BEAT(TICKS_PER_BEAT),
        .PRESCALE      (PRESCALE)
    ) UUT (
        .clk    (clk),
        .reset  (reset),
        .state  (state),
        .mute   (mute),
        .audio_l(audio_l),
        .audio_r(audio_r)
    );

    always #50 clk = ~clk;

    task automatic stop_on_failure(input string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic report_mismatch(input string test, input int expected, input int actual);
        stop_on_failure($sformatf("mismatch %s expected %0d actual %0d", test, expected, actual));
    endtask

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // song a state should select, from the grouping rules.
    function automatic song_id_t expected_song(input logic [3:0] code, input logic muted);
        if (muted) begin
            return SONG_SILENT;
        end
        case (game_state_t'(code))
            TITLE:                        return SONG_TITLE;
            STAFF:                        return SONG_STAFF;
            STAGE1, STAGE2, STAGE3:       return SONG_STAGE;
            SUCCESS1, SUCCESS2, SUCCESS3: return SONG_SUCCESS;
            FAIL:                         return SONG_FAIL;
            HELP:                         return SONG_HELP;
            default:                      return SONG_SILENT;
        endcase
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #10;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model, one register stage per pipeline stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin : reference_model
        logic [BEAT_BITS-1:0] idx_next;
        if (reset) begin
            cycle_cnt <= 0;
            exp_beat  <= 1'b0;
            exp_song  <= SONG_SILENT;
            seen_song <= SONG_SILENT;
            exp_idx   <= '0;
            exp_note  <= NOTE_SILENT;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
            exp_beat  <= ((cycle_cnt + 1) % TICKS_PER_BEAT == 0); // strobe every beat.
            exp_song  <= expected_song(state, mute);
            if (exp_song != seen_song) begin
                idx_next = '0;
            end else if (exp_beat) begin
                idx_next = (exp_idx + 1 == song_length(exp_song)) ? '0 : exp_idx + 1'b1;
            end else begin
                idx_next = exp_idx;
            end
            seen_song <= exp_song;
            exp_idx   <= idx_next;
            exp_note  <= song_note(exp_song, idx_next);
        end
    end

    assign wave_now[0] = audio_l;
    assign wave_now[1] = audio_r;
    assign hp_now[0]   = exp_note.left;
    assign hp_now[1]   = exp_note.right;

    always @(posedge clk) begin
        for (int ch = 0; ch < 2; ch++) begin
            if (reset) begin
                wave_prev[ch]    <= 1'b0;
                hp_last[ch]      <= '0;
                restart_pend[ch] <= 1'b0;
                run_len[ch]      <= 0;
            end else begin
                if (restart_pend[ch] || (wave_now[ch] != wave_prev[ch])) begin
                    run_len[ch] <= 1; // fresh run.
                end else begin
                    run_len[ch] <= run_len[ch] + 1;
                end
                wave_prev[ch]    <= wave_now[ch];
                restart_pend[ch] <= (hp_now[ch] != hp_last[ch]);
                hp_last[ch]      <= hp_now[ch];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar ch = 0; ch < 2; ch++) begin : g_check
        run_matches_note: assert property (
            @(posedge clk) disable iff (reset)
            (!restart_pend[ch] && (wave_now[ch] != wave_prev[ch])) |->
                (run_len[ch] == hp_last[ch])
        ) else report_mismatch(test_name, $sampled(hp_last[ch]), $sampled(run_len[ch]));

        note_starts_high: assert property (
            @(posedge clk) disable iff (reset)
            restart_pend[ch] |-> (wave_now[ch] == (hp_last[ch] != '0))
        ) else report_mismatch(test_name, $sampled(hp_last[ch] != '0), $sampled(wave_now[ch]));

        rest_is_low: assert property (
            @(posedge clk) disable iff (reset)
            (hp_last[ch] == '0) |-> !wave_now[ch]
        ) else report_mismatch(test_name, 0, $sampled(wave_now[ch]));
    end

    quiet_before_state: assert property (
        @(posedge clk) disable iff (reset)
        !state_applied |-> (wave_now == 2'b00)
    ) else report_mismatch(test_name, 0, $sampled(wave_now));

    mute_silences: assert property (
        @(posedge clk) disable iff (reset)
        mute [*4] |-> (wave_now == 2'b00)
    ) else report_mismatch(test_name, 0, $sampled(wave_now));

    always @(posedge clk) begin
        cycles_run <= cycles_run + 1;
        if (cycles_run >= CYCLE_LIMIT) begin
            stop_on_failure("timeout: the test sequence did not finish in time");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int          start;
        int          beats;
        logic [3:0]  code;
        logic [31:0] r;
        clk   = 1'b0;
        reset = 1'b1;
        state = game_state_t'(4'hF); // undefined code, silent.
        mute  = 1'b0;
        wait_cycles(3);
        reset = 1'b0;
        wait_cycles(200);
        state_applied = 1'b1;
        start = next_random() % 16;
        for (int v = 0; v < VISITS; v++) begin
            // a permutation first, so every code is played once.
            code = (v < 16) ? 4'((v * 5 + start) % 16) : 4'(next_random() % 16);
            test_name = $sformatf("visit %0d state %0d", v, code);
            state = game_state_t'(code);
            beats = song_length(expected_song(code, 1'b0)) + 2;
            wait_cycles(beats * TICKS_PER_BEAT + next_random() % 777);
            r = next_random();
            if (r[0]) begin
                test_name = $sformatf("visit %0d state %0d muted", v, code);
                mute = 1'b1;
                wait_cycles(TICKS_PER_BEAT + r[15:8]);
                test_name = $sformatf("visit %0d state %0d unmuted", v, code);
                mute = 1'b0;
                wait_cycles(beats * TICKS_PER_BEAT);
            end
        end
        wait_cycles(20);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tone_pkg.sv ====
// pitches assume a 100 MHz clock divided by 256; 10 bits put the lowest pitch near 191 Hz.
`default_nettype none

package tone_pkg;

    localparam int HP_BITS = 10;

    // half-period in prescaled ticks, zero is silence.
    typedef logic [HP_BITS-1:0] half_period_t;

    typedef struct packed {
        half_period_t left;
        half_period_t right;
    } stereo_note_t;

    localparam stereo_note_t NOTE_SILENT = '{left: '0, right: '0};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pitch table, 390625 Hz tick over twice the note frequency
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam half_period_t HP_G3 = 10'd996;
    localparam half_period_t HP_A3 = 10'd888;
    localparam half_period_t HP_B3 = 10'd791;
    localparam half_period_t HP_C4 = 10'd747;
    localparam half_period_t HP_D4 = 10'd665;
    localparam half_period_t HP_E4 = 10'd593;
    localparam half_period_t HP_F4 = 10'd559;
    localparam half_period_t HP_G4 = 10'd498;
    localparam half_period_t HP_A4 = 10'd444;
    localparam half_period_t HP_B4 = 10'd395;
    localparam half_period_t HP_C5 = 10'd373;
    localparam half_period_t HP_D5 = 10'd333;
    localparam half_period_t HP_E5 = 10'd296;

endpackage

`default_nettype wire

// ==== verilog.f ====
+incdir+.
sound_pkg.sv
tone_pkg.sv
beat_timer.sv
game_sound.sv
song_sequencer.sv
square_voice.sv
sound_top.sv
tb_sound_top.sv
